//--- rtl/burst_pkg.sv
package burst_pkg;

	//////////////////////////////
	// Address and length limits
	//////////////////////////////

	// Byte address on the burst bus
	typedef logic [31:0] addr_t;

	// No burst may cross a page of this size
	localparam int unsigned PAGE_BYTES = 4096;

	// Longest burst in beats
	localparam int unsigned MAX_BEATS = 256;

	// Burst length, 1 to 256 beats
	typedef logic [8:0] burst_len_t;

	//////////////////////////////
	// Command and beat records
	//////////////////////////////

	// One burst as issued by a splitter
	typedef struct packed {
		addr_t      addr;
		burst_len_t len;
		logic       src;
	} burst_cmd_t;

	// One beat as driven by the sequencer
	typedef struct packed {
		addr_t addr;
		logic  src;
		// High on the final beat of its burst
		logic  last;
	} beat_t;

endpackage

//--- rtl/burst_splitter.sv
`timescale 1ns/1ns

module burst_splitter
	import burst_pkg::*;
#(
	parameter int unsigned BEAT_BYTES = 4,
	parameter bit          SRC        = 1'b0
)(
	input  logic       sys_clk,
	input  logic       reset_n,

	// Client side
	input  logic       s_req,
	input  addr_t      s_addr,
	input  logic [31:0] s_len,
	input  logic       s_ready,
	output logic       s_ack,
	output logic       s_done,

	// Toward the arbiter
	output logic       burst_req,
	output burst_cmd_t burst_cmd,
	input  logic       burst_ack,
	input  logic       burst_done
);

	localparam int unsigned PAGE_BITS  = $clog2(PAGE_BYTES);
	localparam int unsigned BEAT_SHIFT = $clog2(BEAT_BYTES);
	localparam int unsigned PAGE_BEATS = PAGE_BYTES / BEAT_BYTES;
	localparam int unsigned ROOM_W     = $clog2(PAGE_BEATS + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_NEXT,
		S_DONE
	} state_t;

	state_t            state;

	// Beats still to issue after the current burst
	logic [31:0]       remain;
	// Beats left before the next page boundary
	logic [ROOM_W-1:0] room;

	logic [31:0]       cur_remain;
	logic [ROOM_W-1:0] cur_room;
	addr_t             cur_addr;
	burst_len_t        cut_len;
	logic [ROOM_W-1:0] room_left;
	logic              accept;
	logic              load;

	// Smallest of remaining length, page room and the burst limit
	function automatic burst_len_t min_len(input logic [31:0] a, input logic [31:0] b);
		logic [31:0] m;
		m = (a < b) ? a : b;
		if (m > MAX_BEATS)
			m = MAX_BEATS;
		return burst_len_t'(m);
	endfunction

	//////////////////////////////
	// Next burst calculation
	//////////////////////////////

	// Zero length requests are ignored
	assign accept = (state == S_IDLE) && s_req && (s_len != 32'd0) && s_ready;
	assign load   = accept || ((state == S_NEXT) && s_ready);

	always_comb begin
		if (state == S_IDLE) begin
			// Fresh transfer, room taken from the page offset
			cur_remain = s_len;
			cur_room   = ROOM_W'((PAGE_BYTES - 32'(s_addr[PAGE_BITS-1:0])) >> BEAT_SHIFT);
			cur_addr   = s_addr;
		end else begin
			cur_remain = remain;
			cur_room   = room;
			// Step past the burst just finished
			cur_addr   = burst_cmd.addr + (addr_t'(burst_cmd.len) << BEAT_SHIFT);
		end
	end

	assign cut_len   = min_len(cur_remain, 32'(cur_room));
	assign room_left = cur_room - ROOM_W'(cut_len);

	//////////////////////////////
	// Control FSM
	//////////////////////////////

	always_ff @(posedge sys_clk or negedge reset_n) begin
		if (!reset_n) begin
			state     <= S_IDLE;
			burst_req <= 1'b0;
			s_ack     <= 1'b0;
		end else begin
			s_ack <= accept;
			case (state)
				S_IDLE: begin
					if (accept) begin
						burst_req <= 1'b1;
						state     <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (burst_ack)
						burst_req <= 1'b0;
					if (burst_done)
						state <= (remain == 32'd0) ? S_DONE : S_NEXT;
				end
				S_NEXT: begin
					// Hold here while the client is not ready
					if (s_ready) begin
						burst_req <= 1'b1;
						state     <= S_WAIT;
					end
				end
				S_DONE: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Command and counters are loaded with each new burst
	always_ff @(posedge sys_clk) begin
		if (load) begin
			burst_cmd.addr <= cur_addr;
			burst_cmd.len  <= cut_len;
			burst_cmd.src  <= SRC;
			remain         <= cur_remain - 32'(cut_len);
			// Page used up, the next burst starts on a fresh page
			if (room_left == '0)
				room <= ROOM_W'(PAGE_BEATS);
			else
				room <= room_left;
		end
	end

	assign s_done = (state == S_DONE);

endmodule

//--- rtl/burst_arbiter.sv
`timescale 1ns/1ns

module burst_arbiter
	import burst_pkg::*;
(
	input  logic       sys_clk,
	input  logic       reset_n,

	// Splitter side
	input  logic [1:0] req,
	input  burst_cmd_t cmd0,
	input  burst_cmd_t cmd1,
	output logic [1:0] ack,
	output logic [1:0] done,

	// Sequencer side
	input  logic       seq_busy,
	input  logic       seq_done,
	output logic       seq_start,
	output burst_cmd_t seq_cmd
);

	// A burst is granted and not yet finished
	logic in_flight;
	// Owner of the burst in flight, also the last source served
	logic owner;
	logic grant;
	logic winner;

	//////////////////////////////
	// Round-robin choice
	//////////////////////////////

	assign grant = !in_flight && !seq_busy && (req != 2'b00);

	always_comb begin
		if (req == 2'b11)
			winner = ~owner;
		else
			winner = req[1];
	end

	always_ff @(posedge sys_clk or negedge reset_n) begin
		if (!reset_n) begin
			in_flight <= 1'b0;
			seq_start <= 1'b0;
			// Channel 0 wins the first tie
			owner     <= 1'b1;
		end else begin
			seq_start <= grant;
			if (grant) begin
				in_flight <= 1'b1;
				owner     <= winner;
			end else if (seq_done) begin
				in_flight <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (grant)
			seq_cmd <= winner ? cmd1 : cmd0;
	end

	// Steer the handshake back to the owner
	assign ack  = seq_start ? {owner, ~owner} : 2'b00;
	assign done = seq_done  ? {owner, ~owner} : 2'b00;

endmodule

//--- rtl/beat_sequencer.sv
`timescale 1ns/1ns

module beat_sequencer
	import burst_pkg::*;
#(
	parameter int unsigned BEAT_BYTES = 4
)(
	input  logic       sys_clk,
	input  logic       reset_n,

	// From the arbiter
	input  logic       seq_start,
	input  burst_cmd_t seq_cmd,
	output logic       seq_busy,
	output logic       seq_done,

	// Beat output
	input  logic       beat_stall,
	output logic       beat_valid,
	output beat_t      beat
);

	logic       busy;
	// Beats left, including the one on the bus
	burst_len_t count;
	addr_t      addr;
	logic       src;
	logic       take;
	logic       final_beat;

	// A beat counts on every unstalled cycle
	assign take       = busy && !beat_stall;
	assign final_beat = (count == burst_len_t'(1));

	//////////////////////////////
	// Burst progress
	//////////////////////////////

	always_ff @(posedge sys_clk or negedge reset_n) begin
		if (!reset_n) begin
			busy     <= 1'b0;
			seq_done <= 1'b0;
		end else begin
			seq_done <= take && final_beat;
			if (seq_start)
				busy <= 1'b1;
			else if (take && final_beat)
				busy <= 1'b0;
		end
	end

	// Load on start, then step the address per counted beat
	always_ff @(posedge sys_clk) begin
		if (seq_start) begin
			addr  <= seq_cmd.addr;
			count <= seq_cmd.len;
			src   <= seq_cmd.src;
		end else if (take) begin
			addr  <= addr + addr_t'(BEAT_BYTES);
			count <= count - burst_len_t'(1);
		end
	end

	assign seq_busy   = busy;
	assign beat_valid = busy;

	assign beat.addr = addr;
	assign beat.src  = src;
	assign beat.last = final_beat;

endmodule

//--- rtl/burst_dma_top.sv
`timescale 1ns/1ns

module burst_dma_top
	import burst_pkg::*;
#(
	parameter int unsigned BEAT_BYTES = 4
)(
	input  logic        sys_clk,
	input  logic        reset_n,

	// Channel 0 client
	input  logic        ch0_req,
	input  addr_t       ch0_addr,
	input  logic [31:0] ch0_len,
	input  logic        ch0_ready,
	output logic        ch0_ack,
	output logic        ch0_done,

	// Channel 1 client
	input  logic        ch1_req,
	input  addr_t       ch1_addr,
	input  logic [31:0] ch1_len,
	input  logic        ch1_ready,
	output logic        ch1_ack,
	output logic        ch1_done,

	// Beat bus
	input  logic        beat_stall,
	output logic        beat_valid,
	output beat_t       beat
);

	logic [1:0] burst_req;
	burst_cmd_t burst_cmd0;
	burst_cmd_t burst_cmd1;
	logic [1:0] burst_ack;
	logic [1:0] burst_done;

	logic       seq_start;
	burst_cmd_t seq_cmd;
	logic       seq_busy;
	logic       seq_done;

	burst_splitter #(
		.BEAT_BYTES (BEAT_BYTES),
		.SRC        (1'b0)
	) splitter0_inst (
		.sys_clk    (sys_clk),
		.reset_n    (reset_n),
		.s_req      (ch0_req),
		.s_addr     (ch0_addr),
		.s_len      (ch0_len),
		.s_ready    (ch0_ready),
		.s_ack      (ch0_ack),
		.s_done     (ch0_done),
		.burst_req  (burst_req[0]),
		.burst_cmd  (burst_cmd0),
		.burst_ack  (burst_ack[0]),
		.burst_done (burst_done[0])
	);

	burst_splitter #(
		.BEAT_BYTES (BEAT_BYTES),
		.SRC        (1'b1)
	) splitter1_inst (
		.sys_clk    (sys_clk),
		.reset_n    (reset_n),
		.s_req      (ch1_req),
		.s_addr     (ch1_addr),
		.s_len      (ch1_len),
		.s_ready    (ch1_ready),
		.s_ack      (ch1_ack),
		.s_done     (ch1_done),
		.burst_req  (burst_req[1]),
		.burst_cmd  (burst_cmd1),
		.burst_ack  (burst_ack[1]),
		.burst_done (burst_done[1])
	);

	burst_arbiter burst_arbiter_inst (
		.sys_clk   (sys_clk),
		.reset_n   (reset_n),
		.req       (burst_req),
		.cmd0      (burst_cmd0),
		.cmd1      (burst_cmd1),
		.ack       (burst_ack),
		.done      (burst_done),
		.seq_busy  (seq_busy),
		.seq_done  (seq_done),
		.seq_start (seq_start),
		.seq_cmd   (seq_cmd)
	);

	beat_sequencer #(
		.BEAT_BYTES (BEAT_BYTES)
	) beat_sequencer_inst (
		.sys_clk    (sys_clk),
		.reset_n    (reset_n),
		.seq_start  (seq_start),
		.seq_cmd    (seq_cmd),
		.seq_busy   (seq_busy),
		.seq_done   (seq_done),
		.beat_stall (beat_stall),
		.beat_valid (beat_valid),
		.beat       (beat)
	);

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
	output logic sys_clk,
	output logic reset_n
);

	// 10 ns period
	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	// Reset held for two rising edges
	initial begin
		reset_n = 1'b0;
		repeat (2) @(posedge sys_clk);
		reset_n <= 1'b1;
	end

endmodule

//--- dv/burst_dma_assert.sv
`timescale 1ns/1ns

module burst_dma_assert
	import burst_pkg::*;
(
	input logic       sys_clk,
	input logic       reset_n,
	input logic       seq_start,
	input burst_cmd_t seq_cmd,
	input logic       seq_busy,
	input logic       beat_valid,
	input beat_t      beat
);

	// Page of the burst being sequenced
	logic [19:0] burst_page;

	always_ff @(posedge sys_clk) begin
		if (seq_start)
			burst_page <= seq_cmd.addr[31:12];
	end

	page_kept: assert property (@(posedge sys_clk) disable iff (!reset_n)
		beat_valid |-> (beat.addr[31:12] == burst_page))
		else $error("beat address left the page of its burst");

	len_in_range: assert property (@(posedge sys_clk) disable iff (!reset_n)
		seq_start |-> ((seq_cmd.len != '0) && (seq_cmd.len <= MAX_BEATS)))
		else $error("burst length outside 1 to MAX_BEATS at seq_start");

	start_when_idle: assert property (@(posedge sys_clk) disable iff (!reset_n)
		seq_start |-> !seq_busy)
		else $error("seq_start while sequencer busy");

endmodule

bind beat_sequencer burst_dma_assert burst_dma_assert_inst (.*);

//--- dv/burst_dma_tb.sv
`timescale 1ns/1ns

module burst_dma_tb
	import burst_pkg::*;
;

	localparam int unsigned BEAT_BYTES = 4;

	logic        sys_clk;
	logic        reset_n;
	logic        ch0_req, ch1_req, ch0_ready, ch1_ready;
	addr_t       ch0_addr, ch1_addr;
	logic [31:0] ch0_len, ch1_len;
	logic        ch0_ack, ch1_ack, ch0_done, ch1_done;
	logic        beat_stall;
	logic        beat_valid;
	beat_t       beat;

	logic [31:0] stim [0:63];
	logic [31:0] lfsr;
	logic        stall_bit;
	int          stall_steps;
	int          wd_limit;
	int          cycle;
	int          ack_cnt [2];
	int          done_cnt [2];
	int          beat_cnt [2];
	int          done_cycle [2];
	int          hold_cycles [2];
	addr_t       run_addr [2];
	int          run_len [2];
	addr_t       exp_addr0 [$];
	addr_t       exp_addr1 [$];
	int          exp_len0 [$];
	int          exp_len1 [$];
	bit          alt_mode;
	bit          have_last;
	logic        last_src;
	string       test_name;

	tb_clock_gen tb_clock_gen_inst (.sys_clk(sys_clk), .reset_n(reset_n));

	burst_dma_top #(.BEAT_BYTES(BEAT_BYTES)) burst_dma_top_inst (
		.sys_clk(sys_clk), .reset_n(reset_n),
		.ch0_req(ch0_req), .ch0_addr(ch0_addr), .ch0_len(ch0_len), .ch0_ready(ch0_ready),
		.ch0_ack(ch0_ack), .ch0_done(ch0_done),
		.ch1_req(ch1_req), .ch1_addr(ch1_addr), .ch1_len(ch1_len), .ch1_ready(ch1_ready),
		.ch1_ack(ch1_ack), .ch1_done(ch1_done),
		.beat_stall(beat_stall), .beat_valid(beat_valid), .beat(beat)
	);

	task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("error %s expected %0h actual %0h", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// Page and length rule applied to one transfer, returns the burst count
	function automatic int build_expected(input int c, input addr_t a, input int len);
		int n;
		int room;
		int bursts;
		bursts = 0;
		while (len > 0) begin
			room = (PAGE_BYTES - (a % PAGE_BYTES)) / BEAT_BYTES;
			n = (len < room) ? len : room;
			if (n > MAX_BEATS)
				n = MAX_BEATS;
			if (c == 0) begin
				exp_addr0.push_back(a);
				exp_len0.push_back(n);
			end else begin
				exp_addr1.push_back(a);
				exp_len1.push_back(n);
			end
			a = a + n * BEAT_BYTES;
			len = len - n;
			bursts++;
		end
		return bursts;
	endfunction

	//////////////////////////////
	// Stall and ready drive
	//////////////////////////////

	always @(posedge sys_clk) begin
		stall_bit = 1'b1;
		for (int i = 0; i < stall_steps; i++) begin
			stall_bit = stall_bit & lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
		beat_stall <= reset_n ? stall_bit : 1'b0;
	end

	// Ready drops after each burst of a channel with a hold set
	initial forever begin
		@(posedge sys_clk);
		if (reset_n && beat_valid && !beat_stall && beat.last && !beat.src &&
				hold_cycles[0] != 0) begin
			ch0_ready <= 1'b0;
			repeat (hold_cycles[0]) @(posedge sys_clk);
			ch0_ready <= 1'b1;
		end
	end

	initial forever begin
		@(posedge sys_clk);
		if (reset_n && beat_valid && !beat_stall && beat.last && beat.src &&
				hold_cycles[1] != 0) begin
			ch1_ready <= 1'b0;
			repeat (hold_cycles[1]) @(posedge sys_clk);
			ch1_ready <= 1'b1;
		end
	end

	//////////////////////////////
	// Monitor
	//////////////////////////////

	always @(posedge sys_clk) begin
		int   s;
		addr_t ea;
		int   el;
		bit   other_pending;
		cycle++;
		if (reset_n) begin
			if (ch0_ack) ack_cnt[0]++;
			if (ch1_ack) ack_cnt[1]++;
			if (ch0_done) begin
				done_cnt[0]++;
				done_cycle[0] = cycle;
			end
			if (ch1_done) begin
				done_cnt[1]++;
				done_cycle[1] = cycle;
			end
			if (beat_valid && !beat_stall) begin
				s = beat.src;
				beat_cnt[s]++;
				if (run_len[s] == 0)
					run_addr[s] = beat.addr;
				else
					compare_value({test_name, "_beat_addr"}, run_addr[s] + run_len[s] * BEAT_BYTES,
						beat.addr);
				run_len[s]++;
				if (beat.last) begin
					if ((s == 0 && exp_len0.size() == 0) || (s == 1 && exp_len1.size() == 0)) begin
						$display("Burst seen on channel %0d with none expected", s);
						$display("Test failed");
						$fatal(1);
					end
					other_pending = (s == 0) ? (exp_len1.size() != 0) : (exp_len0.size() != 0);
					if (alt_mode && have_last && other_pending)
						compare_value({test_name, "_alternation"}, !last_src, s);
					have_last = 1'b1;
					last_src = s;
					ea = (s == 0) ? exp_addr0.pop_front() : exp_addr1.pop_front();
					el = (s == 0) ? exp_len0.pop_front() : exp_len1.pop_front();
					compare_value({test_name, "_burst_addr"}, ea, run_addr[s]);
					compare_value({test_name, "_burst_len"}, el, run_len[s]);
					run_len[s] = 0;
				end
			end
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	task automatic run_group(input int g, input int n_entries);
		int ent [$];
		int c, len, hold_other;
		int ack0 [2];
		int done0 [2];
		int beat0 [2];
		bit zero_len;
		zero_len = 1'b0;
		for (int e = 0; e < n_entries; e++)
			if (stim[2 + e * 6] == g)
				ent.push_back(2 + e * 6);
		test_name = $sformatf("group%0d", g);
		alt_mode = (ent.size() == 2) && (stim[ent[0] + 5] == 0) && (stim[ent[1] + 5] == 0);
		have_last = 1'b0;
		foreach (ent[i]) begin
			c = stim[ent[i] + 1];
			compare_value({test_name, "_burst_count"}, stim[ent[i] + 4],
				build_expected(c, stim[ent[i] + 2], stim[ent[i] + 3]));
			hold_cycles[c] = stim[ent[i] + 5];
			ack0[c] = ack_cnt[c];
			done0[c] = done_cnt[c];
			beat0[c] = beat_cnt[c];
		end
		@(posedge sys_clk);
		foreach (ent[i]) begin
			if (stim[ent[i] + 1] == 0) begin
				ch0_req <= 1'b1;
				ch0_addr <= stim[ent[i] + 2];
				ch0_len <= stim[ent[i] + 3];
			end else begin
				ch1_req <= 1'b1;
				ch1_addr <= stim[ent[i] + 2];
				ch1_len <= stim[ent[i] + 3];
			end
		end
		@(posedge sys_clk);
		ch0_req <= 1'b0;
		ch1_req <= 1'b0;
		foreach (ent[i]) begin
			c = stim[ent[i] + 1];
			len = stim[ent[i] + 3];
			if (len == 0)
				zero_len = 1'b1;
			else
				while (done_cnt[c] < done0[c] + 1) @(posedge sys_clk);
		end
		if (zero_len)
			repeat (30) @(posedge sys_clk);
		foreach (ent[i]) begin
			c = stim[ent[i] + 1];
			len = stim[ent[i] + 3];
			compare_value({test_name, "_ack_count"}, (len != 0), ack_cnt[c] - ack0[c]);
			compare_value({test_name, "_done_count"}, (len != 0), done_cnt[c] - done0[c]);
			compare_value({test_name, "_beat_count"}, len, beat_cnt[c] - beat0[c]);
		end
		// A channel held off by ready must finish after the other one
		if (ent.size() == 2) begin
			c = stim[ent[0] + 1];
			hold_other = stim[ent[1] + 5];
			if (stim[ent[0] + 5] != 0 && hold_other == 0)
				compare_value({test_name, "_held_done_later"}, 1,
					done_cycle[c] > done_cycle[1 - c]);
			if (hold_other != 0 && stim[ent[0] + 5] == 0)
				compare_value({test_name, "_held_done_later"}, 1,
					done_cycle[1 - c] > done_cycle[c]);
		end
		hold_cycles[0] = 0;
		hold_cycles[1] = 0;
	endtask

	initial begin
		int n_entries;
		int n_groups;
		int total;
		ch0_req = 1'b0;
		ch1_req = 1'b0;
		ch0_addr = '0;
		ch1_addr = '0;
		ch0_len = '0;
		ch1_len = '0;
		ch0_ready = 1'b1;
		ch1_ready = 1'b1;
		beat_stall = 1'b0;
		lfsr = 32'he549_5855;
		cycle = 0;
		wd_limit = 0;
		hold_cycles = '{0, 0};
		run_len = '{0, 0};
		$readmemh("dv/burst_dma_stimulus.txt", stim);
		stall_steps = stim[0];
		n_entries = stim[1];
		n_groups = 0;
		total = 0;
		for (int e = 0; e < n_entries; e++) begin
			total += stim[2 + e * 6 + 3];
			if (stim[2 + e * 6] + 1 > n_groups)
				n_groups = stim[2 + e * 6] + 1;
		end
		wd_limit = 20 * total + 200;
		wait (reset_n === 1'b1);
		for (int g = 0; g < n_groups; g++)
			run_group(g, n_entries);
		compare_value("end_expected_left", 0, exp_len0.size() + exp_len1.size());
		$display("Test completed successfully");
		$finish;
	end

	initial begin
		wait (wd_limit != 0);
		repeat (wd_limit) @(posedge sys_clk);
		$display("Timeout: transfers did not complete within %0d cycles", wd_limit);
		$display("Test failed");
		$fatal(1);
	end

endmodule

//--- dv/burst_dma_stimulus.txt
// word 0: LFSR steps per stall decision, word 1: number of transfers
// then per transfer: group channel start_addr length expected_bursts ready_hold_cycles
00000002 00000009
00000000 00000000 00001000 00000258 00000003 00000000
00000001 00000001 00002FF0 00000200 00000003 00000000
00000002 00000000 00010000 0000012C 00000002 00000000
00000002 00000001 00020000 0000012C 00000002 00000000
00000003 00000000 00030100 00000020 00000001 00000000
00000003 00000001 00031FFC 00000010 00000002 00000000
00000004 00000000 00040000 00000200 00000002 00000040
00000004 00000001 00050000 00000040 00000001 00000000
00000005 00000001 00060000 00000000 00000000 00000000

//--- burst_dma_top.f
rtl/burst_pkg.sv
rtl/burst_splitter.sv
rtl/burst_arbiter.sv
rtl/beat_sequencer.sv
rtl/burst_dma_top.sv
dv/tb_clock_gen.sv
dv/burst_dma_assert.sv
dv/burst_dma_tb.sv

//--- Makefile
TOP := burst_dma_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f burst_dma_top.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing -f burst_dma_top.f --top-module $(TOP)
	verilator --lint-only rtl/burst_pkg.sv rtl/burst_splitter.sv rtl/burst_arbiter.sv \
		rtl/beat_sequencer.sv rtl/burst_dma_top.sv --top-module burst_dma_top

clean:
	rm -rf obj_dir
